// ==== hdl/tenyr_soc_pkg.sv ====
`default_nettype none

package tenyr_soc_pkg;

    // bus word and address sizes
    localparam int data_width = 32;
    localparam int addr_width = 32;

    // ram occupies word addresses 0 .. ram_words-1
    localparam int ram_words     = 1024;
    localparam int ram_addr_bits = $clog2(ram_words);

    // single-word devices above the ram
    localparam logic [addr_width-1:0] seg7_addr = 32'h0000_1000;
    localparam logic [addr_width-1:0] ctrl_addr = 32'h0000_1001;

    localparam int startup_len = 4; // core clocks held halted after reset

    // top two bits of the scan counter pick the digit
    localparam int seg7_refresh_bits = 4;

    localparam int halt_width = 8; // halt vector, also the led width

    // device selected by an operand address
    typedef enum logic [1:0] {
        sel_ram  = 2'd0,
        sel_seg7 = 2'd1,
        sel_ctrl = 2'd2,
        sel_none = 2'd3
    } dev_sel_t;

endpackage

`default_nettype wire

// ==== hdl/system_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module system_control (
    input  logic                                   clk_core,
    input  logic                                   rst_n,
    input  logic                                   ctrl_we,
    input  logic [tenyr_soc_pkg::data_width-1:0]   oper_wdata,
    output logic                                   sys_rst_n,
    output logic                                   fetch_en,
    output logic [tenyr_soc_pkg::data_width-1:0]   ctrl_value,
    output logic [tenyr_soc_pkg::halt_width-1:0]   Led
);

    import tenyr_soc_pkg::*;

    logic [startup_len-1:0]  startup_q;   // fills with ones after reset
    logic [halt_width-1:1]   halt_bits_q; // software halt bits
    logic [halt_width-1:0]   halt_vec;
    logic                    startup_busy;

    // ones shift in from the bottom once rst_n is released
    always_ff @(posedge clk_core or negedge rst_n) begin
        if (!rst_n) begin
            startup_q <= '0;
        end else begin
            startup_q <= {startup_q[startup_len-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk_core or negedge rst_n) begin
        if (!rst_n) begin
            halt_bits_q <= '0;
        end else if (ctrl_we) begin
            halt_bits_q <= oper_wdata[halt_width-1:1];
        end
    end

    assign startup_busy = ~startup_q[startup_len-1];
    assign sys_rst_n    = startup_q[startup_len-1]; // last stage frees the system
    assign fetch_en     = startup_q[2];             // third stage opens fetch

    // bit 0 reports startup still running
    assign halt_vec   = {halt_bits_q, startup_busy};
    assign Led        = halt_vec;
    assign ctrl_value = {{(data_width-halt_width){1'b0}}, halt_vec};

    // internal reset must not drop again without an external reset
    a_sys_rst_sticky: assert property (
        @(posedge clk_core) disable iff (!rst_n)
        sys_rst_n |=> sys_rst_n
    ) else $error("sys_rst_n fell while rst_n was high");

endmodule

`default_nettype wire

// ==== hdl/bus_fabric.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_fabric (
    input  logic                                  clk_core,
    input  logic                                  sys_rst_n,
    input  logic                                  oper_strobe,
    input  logic                                  oper_rw,
    input  logic [tenyr_soc_pkg::addr_width-1:0]  oper_addr,
    input  logic [tenyr_soc_pkg::data_width-1:0]  ram_rdata,
    input  logic [15:0]                           seg7_value,
    input  logic [tenyr_soc_pkg::data_width-1:0]  ctrl_value,
    output logic                                  ram_en,
    output logic                                  ram_we,
    output logic                                  seg7_we,
    output logic                                  ctrl_we,
    output logic [tenyr_soc_pkg::data_width-1:0]  oper_rdata
);

    import tenyr_soc_pkg::*;

    dev_sel_t               dec_sel;
    dev_sel_t               rd_sel_q;   // device of the last read
    logic                   rd_pend_q;  // read answer is on the bus this cycle
    logic [data_width-1:0]  rd_word;
    logic [data_width-1:0]  hold_q;

    always_comb begin
        if (oper_addr < ram_words)       dec_sel = sel_ram;
        else if (oper_addr == seg7_addr) dec_sel = sel_seg7;
        else if (oper_addr == ctrl_addr) dec_sel = sel_ctrl;
        else                             dec_sel = sel_none;
    end

    assign ram_en  = oper_strobe && (dec_sel == sel_ram);  // reads and writes
    assign ram_we  = ram_en && oper_rw;
    assign seg7_we = oper_strobe && oper_rw && (dec_sel == sel_seg7);
    assign ctrl_we = oper_strobe && oper_rw && (dec_sel == sel_ctrl);

    always_ff @(posedge clk_core or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rd_sel_q  <= sel_none;
            rd_pend_q <= 1'b0;
            hold_q    <= '0;
        end else begin
            rd_pend_q <= oper_strobe && !oper_rw;
            if (oper_strobe && !oper_rw) rd_sel_q <= dec_sel;
            if (rd_pend_q)               hold_q   <= rd_word; // keep answer till next read
        end
    end

    always_comb begin
        case (rd_sel_q)
            sel_ram:  rd_word = ram_rdata;
            sel_seg7: rd_word = {{(data_width-16){1'b0}}, seg7_value};
            sel_ctrl: rd_word = ctrl_value;
            default:  rd_word = '0;   // unmapped
        endcase
    end

    assign oper_rdata = rd_pend_q ? rd_word : hold_q;

    a_one_write: assert property (
        @(posedge clk_core) disable iff (!sys_rst_n)
        $onehot0({ram_we, seg7_we, ctrl_we})
    ) else $error("more than one device write enable");

endmodule

`default_nettype wire

// ==== hdl/block_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module block_ram (
    input  logic                                  clk_core,
    input  logic                                  ram_en,
    input  logic                                  ram_we,
    input  logic [tenyr_soc_pkg::addr_width-1:0]  oper_addr,
    input  logic [tenyr_soc_pkg::data_width-1:0]  oper_wdata,
    input  logic                                  fetch_en,
    input  logic [tenyr_soc_pkg::addr_width-1:0]  insn_addr,
    output logic [tenyr_soc_pkg::data_width-1:0]  ram_rdata,
    output logic [tenyr_soc_pkg::data_width-1:0]  insn_data
);

    import tenyr_soc_pkg::*;

    logic [data_width-1:0]     mem [ram_words];
    logic [ram_addr_bits-1:0]  a_idx;
    logic [ram_addr_bits-1:0]  b_idx;

    assign a_idx = oper_addr[ram_addr_bits-1:0];
    assign b_idx = insn_addr[ram_addr_bits-1:0];

    // power-up contents, as a loaded bitstream would give
    initial begin
        for (int i = 0; i < ram_words; i++) begin
            mem[i] = '0;
        end
    end

    // port A, operand side
    always_ff @(posedge clk_core) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[a_idx] <= oper_wdata;
            end else begin
                ram_rdata <= mem[a_idx]; // held until the next read
            end
        end
    end

    // port B, instruction fetch, read only
    always_ff @(posedge clk_core) begin
        if (fetch_en) begin
            insn_data <= mem[b_idx];
        end
    end

    // only the fabric's ram window may reach this port
    a_addr_range: assert property (
        @(posedge clk_core)
        ram_en |-> (oper_addr < ram_words)
    ) else $error("ram access outside the ram window");

endmodule

`default_nettype wire

// ==== hdl/seg7_display.sv ====
`timescale 1ns/10ps
`default_nettype none

module seg7_display (
    input  logic                                  clk_core,
    input  logic                                  sys_rst_n,
    input  logic                                  seg7_we,
    input  logic [tenyr_soc_pkg::data_width-1:0]  oper_wdata,
    output logic [15:0]                           seg7_value,
    output logic [7:0]                            seg,
    output logic [3:0]                            an
);

    import tenyr_soc_pkg::*;

    logic [15:0]                   value_q;
    logic [seg7_refresh_bits-1:0]  scan_q;   // free running
    logic [1:0]                    digit;
    logic [3:0]                    nibble;
    logic [6:0]                    pattern;  // active high, bit 0 = a

    always_ff @(posedge clk_core or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            value_q <= '0;
        end else if (seg7_we) begin
            value_q <= oper_wdata[15:0];
        end
    end

    always_ff @(posedge clk_core or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            scan_q <= '0;
        end else begin
            scan_q <= scan_q + 1'b1;
        end
    end

    assign digit  = scan_q[seg7_refresh_bits-1 -: 2];
    assign nibble = value_q[{digit, 2'b00} +: 4]; // digit 0 is the low nibble

    always_comb begin
        case (nibble)
            4'h0: pattern = 7'h3f;
            4'h1: pattern = 7'h06;
            4'h2: pattern = 7'h5b;
            4'h3: pattern = 7'h4f;
            4'h4: pattern = 7'h66;
            4'h5: pattern = 7'h6d;
            4'h6: pattern = 7'h7d;
            4'h7: pattern = 7'h07;
            4'h8: pattern = 7'h7f;
            4'h9: pattern = 7'h6f;
            4'ha: pattern = 7'h77;
            4'hb: pattern = 7'h7c; // lower case b
            4'hc: pattern = 7'h39;
            4'hd: pattern = 7'h5e; // lower case d
            4'he: pattern = 7'h79;
            default: pattern = 7'h71;
        endcase
    end

    // registered drivers, everything dark in reset
    always_ff @(posedge clk_core or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            seg <= 8'hff;
            an  <= 4'hf;
        end else begin
            seg <= {1'b1, ~pattern};        // dp stays off
            an  <= ~(4'b0001 << digit);
        end
    end

    assign seg7_value = value_q;

    // first driven anode shows up one clock after release
    a_one_anode: assert property (
        @(posedge clk_core) disable iff (!sys_rst_n)
        $past(sys_rst_n) |-> $onehot(~an)
    ) else $error("anode drive is not one-hot low");

endmodule

`default_nettype wire

// ==== hdl/tenyr_soc.sv ====
`timescale 1ns/10ps
`default_nettype none

module tenyr_soc (
    input  logic                                  clk_core,
    input  logic                                  rst_n,
    input  logic                                  oper_strobe,
    input  logic                                  oper_rw,
    input  logic [tenyr_soc_pkg::addr_width-1:0]  oper_addr,
    input  logic [tenyr_soc_pkg::data_width-1:0]  oper_wdata,
    input  logic [tenyr_soc_pkg::addr_width-1:0]  insn_addr,
    output logic [tenyr_soc_pkg::data_width-1:0]  oper_rdata,
    output logic [tenyr_soc_pkg::data_width-1:0]  insn_data,
    output logic [tenyr_soc_pkg::halt_width-1:0]  Led,
    output logic [7:0]                            seg,
    output logic [3:0]                            an
);

    import tenyr_soc_pkg::*;

    logic                   sys_rst_n;
    logic                   fetch_en;
    logic                   ram_en;
    logic                   ram_we;
    logic                   seg7_we;
    logic                   ctrl_we;
    logic [data_width-1:0]  ram_rdata;
    logic [data_width-1:0]  ctrl_value;
    logic [15:0]            seg7_value;

    system_control i_system_control (
        .clk_core   ( clk_core   ), .rst_n      ( rst_n      ),
        .ctrl_we    ( ctrl_we    ), .oper_wdata ( oper_wdata ),
        .sys_rst_n  ( sys_rst_n  ), .fetch_en   ( fetch_en   ),
        .ctrl_value ( ctrl_value ), .Led        ( Led        )
    );

    bus_fabric i_bus_fabric (
        .clk_core    ( clk_core    ), .sys_rst_n  ( sys_rst_n  ),
        .oper_strobe ( oper_strobe ), .oper_rw    ( oper_rw    ),
        .oper_addr   ( oper_addr   ), .ram_rdata  ( ram_rdata  ),
        .seg7_value  ( seg7_value  ), .ctrl_value ( ctrl_value ),
        .ram_en      ( ram_en      ), .ram_we     ( ram_we     ),
        .seg7_we     ( seg7_we     ), .ctrl_we    ( ctrl_we    ),
        .oper_rdata  ( oper_rdata  )
    );

    // port B opens partway through startup
    block_ram i_block_ram (
        .clk_core   ( clk_core   ), .ram_en    ( ram_en    ),
        .ram_we     ( ram_we     ), .oper_addr ( oper_addr ),
        .oper_wdata ( oper_wdata ), .fetch_en  ( fetch_en  ),
        .insn_addr  ( insn_addr  ), .ram_rdata ( ram_rdata ),
        .insn_data  ( insn_data  )
    );

    seg7_display i_seg7_display (
        .clk_core   ( clk_core   ), .sys_rst_n  ( sys_rst_n  ),
        .seg7_we    ( seg7_we    ), .oper_wdata ( oper_wdata ),
        .seg7_value ( seg7_value ), .seg        ( seg        ),
        .an         ( an         )
    );

endmodule

`default_nettype wire

// ==== sim/soc_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module soc_checker (
    input  logic                                  clk_core,
    input  logic [tenyr_soc_pkg::data_width-1:0]  oper_rdata,
    input  logic [tenyr_soc_pkg::data_width-1:0]  insn_data,
    input  logic [tenyr_soc_pkg::halt_width-1:0]  Led,
    input  logic [7:0]                            seg,
    input  logic [3:0]                            an,
    input  logic                                  exp_valid,
    input  logic [2:0]                            exp_kind,
    input  logic [31:0]                           exp_word,
    input  logic                                  test_end,
    input  int                                    test_num,
    input  logic                                  run_done,
    output int                                    err_total
);

    localparam logic [2:0] kind_rdata = 3'd0;
    localparam logic [2:0] kind_insn  = 3'd1;
    localparam logic [2:0] kind_led   = 3'd2;
    localparam logic [2:0] kind_scan  = 3'd3; // exp_word holds the display value
    localparam logic [2:0] kind_dark  = 3'd4;

    localparam int scan_len = 16; // clocks in one full anode walk

    // hex font from digit f down to 0 with bit 0 as segment a
    localparam logic [16*7-1:0] hex_font = {7'h71, 7'h79, 7'h5e, 7'h39, 7'h7c, 7'h77,
        7'h6f, 7'h7f, 7'h07, 7'h7d, 7'h6d, 7'h66, 7'h4f, 7'h5b, 7'h06, 7'h3f};

    int          checks       = 0;
    int          errs         = 0;
    int          total_checks = 0;
    int          total_errs   = 0;
    int          failed_tests = 0;
    int          digit;
    logic [7:0]  seg_exp;
    int          scan_cycles  = 0;
    int          lit_count [4] = '{0, 0, 0, 0}; // clocks each digit was lit this scan

    assign err_total = total_errs;

    // index of the one driven anode or -1 if not exactly one
    function automatic int low_anode(input logic [3:0] drive);
        int idx;
        int lows;
        idx = -1;
        lows = 0;
        for (int i = 0; i < 4; i++) begin
            if (drive[i] === 1'b0) begin
                idx = i;
                lows++;
            end
        end
        return (lows == 1) ? idx : -1;
    endfunction

    task automatic mismatch(input string what, input logic [31:0] got,
                            input logic [31:0] want);
        $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
        errs++;
    endtask

    initial $timeformat(-9, 0, " ns", 0);

    // expectations change on the falling edge and are settled here
    always @(posedge clk_core) begin
        if (exp_valid) begin
            checks++;
            case (exp_kind)
                kind_rdata: if (oper_rdata !== exp_word)
                    mismatch("oper_rdata", oper_rdata, exp_word);
                kind_insn: if (insn_data !== exp_word)
                    mismatch("insn_data", insn_data, exp_word);
                kind_led: if (Led !== exp_word[7:0])
                    mismatch("Led", {24'h0, Led}, exp_word);
                kind_scan: begin
                    digit = low_anode(an);
                    if (digit < 0) begin
                        $display("Error at %0t: anode drive %b does not light exactly one digit",
                                 $time, an);
                        errs++;
                    end else begin
                        lit_count[digit]++;
                        seg_exp = {1'b1, ~hex_font[exp_word[digit*4 +: 4]*7 +: 7]};
                        if (seg !== seg_exp)
                            mismatch("seg", {24'h0, seg}, {24'h0, seg_exp});
                    end
                    scan_cycles++;
                    if (scan_cycles == scan_len) begin
                        // every digit gets a quarter of the walk
                        for (int i = 0; i < 4; i++) begin
                            if (lit_count[i] != scan_len / 4) begin
                                $display("Error at %0t: digit %0d lit for %0d of %0d scan cycles",
                                         $time, i, lit_count[i], scan_len);
                                errs++;
                            end
                            lit_count[i] = 0;
                        end
                        scan_cycles = 0;
                    end
                end
                kind_dark: if ({an, seg} !== 12'hfff)
                    mismatch("an/seg", {20'h0, an, seg}, 32'hfff);
                default: ;
            endcase
        end
        if (test_end) begin
            if (errs == 0)
                $display("test %0d passed, %0d checks", test_num, checks);
            else
                $display("test %0d failed, %0d checks, %0d errors", test_num, checks, errs);
            total_checks += checks;
            total_errs   += errs;
            if (errs != 0) failed_tests++;
            checks = 0;
            errs   = 0;
        end
        if (run_done)
            $display("tests failed %0d, checks %0d, errors %0d",
                     failed_tests, total_checks, total_errs);
    end

endmodule

`default_nettype wire

// ==== sim/tb_tenyr_soc.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_tenyr_soc;

    import tenyr_soc_pkg::*;

    localparam int clk_period   = 40;
    localparam int ram_ops      = 200;
    localparam int fetch_ops    = 64;
    localparam int disp_vals    = 4;
    localparam int ctrl_writes  = 6;
    localparam int unmapped_ops = 6;
    // startup, ram, fetch, display, control, wrap up
    localparam int cycle_budget = 20 + (2 * ram_ops + 3) + (fetch_ops + 2)
                                  + (disp_vals * 20 + 1)
                                  + (ctrl_writes * 4 + unmapped_ops * 6 + 3) + 2;
    localparam int margin_cycles = 100;

    localparam logic [2:0] kind_rdata = 3'd0;
    localparam logic [2:0] kind_insn  = 3'd1;
    localparam logic [2:0] kind_led   = 3'd2;
    localparam logic [2:0] kind_scan  = 3'd3;
    localparam logic [2:0] kind_dark  = 3'd4;

    logic                   clk_core = 1'b0;
    logic                   rst_n;
    logic                   oper_strobe;
    logic                   oper_rw;
    logic [addr_width-1:0]  oper_addr;
    logic [data_width-1:0]  oper_wdata;
    logic [addr_width-1:0]  insn_addr;
    logic [data_width-1:0]  oper_rdata;
    logic [data_width-1:0]  insn_data;
    logic [halt_width-1:0]  Led;
    logic [7:0]             seg;
    logic [3:0]             an;

    logic                   exp_valid;
    logic [2:0]             exp_kind;
    logic [31:0]            exp_word;
    logic                   test_end;
    int                     test_num;
    logic                   run_done;
    int                     err_total;

    // reference model
    logic [31:0]  ram_model [ram_words];
    logic [15:0]  disp_model;
    logic [7:1]   halt_model;
    logic [31:0]  rd_next;    // oper_rdata during the next cycle
    logic [31:0]  insn_next;  // insn_data during the next cycle
    logic [31:0]  written [$];
    logic [31:0]  addr;

    tenyr_soc i_tenyr_soc (
        .clk_core    ( clk_core    ), .rst_n      ( rst_n      ),
        .oper_strobe ( oper_strobe ), .oper_rw    ( oper_rw    ),
        .oper_addr   ( oper_addr   ), .oper_wdata ( oper_wdata ),
        .insn_addr   ( insn_addr   ), .oper_rdata ( oper_rdata ),
        .insn_data   ( insn_data   ), .Led        ( Led        ),
        .seg         ( seg         ), .an         ( an         )
    );

    soc_checker i_soc_checker (
        .clk_core  ( clk_core  ), .oper_rdata ( oper_rdata ), .insn_data ( insn_data ),
        .Led       ( Led       ), .seg        ( seg        ), .an        ( an        ),
        .exp_valid ( exp_valid ), .exp_kind   ( exp_kind   ), .exp_word  ( exp_word  ),
        .test_end  ( test_end  ), .test_num   ( test_num   ), .run_done  ( run_done  ),
        .err_total ( err_total )
    );

    always #(clk_period / 2) clk_core = ~clk_core;

    initial begin
        #((cycle_budget + margin_cycles) * clk_period);
        $display("watchdog: run still busy after %0d cycles", cycle_budget + margin_cycles);
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [31:0] model_read(input logic [31:0] a);
        if (a < ram_words) return ram_model[a[ram_addr_bits-1:0]];
        else if (a == seg7_addr) return {16'h0, disp_model};
        else if (a == ctrl_addr) return {24'h0, halt_model, 1'b0};
        else return '0; // unmapped
    endfunction

    task automatic model_write(input logic [31:0] a, input logic [31:0] d);
        if (a < ram_words) begin
            ram_model[a[ram_addr_bits-1:0]] = d;
            written.push_back(a);
        end else if (a == seg7_addr) begin
            disp_model = d[15:0];
        end else if (a == ctrl_addr) begin
            halt_model = d[7:1];
        end
    endtask

    task automatic set_check(input logic [2:0] kind, input logic [31:0] word);
        exp_valid = 1'b1;
        exp_kind  = kind;
        exp_word  = word;
    endtask

    // one strobe, and the held read word checked at the same time
    task automatic bus_cycle(input logic rw, input logic [31:0] a, input logic [31:0] d);
        set_check(kind_rdata, rd_next);
        oper_strobe = 1'b1;
        oper_rw     = rw;
        oper_addr   = a;
        oper_wdata  = d;
        if (rw) model_write(a, d);
        else rd_next = model_read(a);
        @(negedge clk_core);
    endtask

    task automatic bus_idle(input int n);
        repeat (n) begin
            set_check(kind_rdata, rd_next);
            oper_strobe = 1'b0;
            @(negedge clk_core);
        end
    endtask

    task automatic fetch_cycle(input logic [31:0] a);
        set_check(kind_insn, insn_next);
        oper_strobe = 1'b0;
        insn_addr   = a;
        insn_next   = ram_model[a[ram_addr_bits-1:0]];
        @(negedge clk_core);
    endtask

    task automatic end_test();
        exp_valid   = 1'b0;
        oper_strobe = 1'b0;
        test_end    = 1'b1;
        @(negedge clk_core);
        test_end = 1'b0;
        test_num++;
    endtask

    function automatic logic [31:0] unmapped_address(input int i);
        if (i % 2 == 0) return 32'h400 + ($urandom % 32'hc00); // between ram and devices
        else return $urandom | 32'h0001_0000;
    endfunction

    initial begin
        void'($urandom(44480));
        rst_n = 1'b0;
        oper_strobe = 1'b0;
        oper_rw = 1'b0;
        oper_addr = '0;
        oper_wdata = '0;
        insn_addr = '0;
        exp_valid = 1'b0;
        exp_kind = kind_rdata;
        exp_word = '0;
        test_end = 1'b0;
        test_num = 1;
        run_done = 1'b0;
        for (int i = 0; i < ram_words; i++) ram_model[i] = '0;
        disp_model = '0;
        halt_model = '0;
        rd_next = '0;

        // startup: display dark in reset, then four halted cycles
        repeat (2) @(negedge clk_core);
        set_check(kind_dark, '0);
        repeat (8) @(negedge clk_core);
        rst_n = 1'b1;
        set_check(kind_led, 32'h01);
        repeat (4) @(negedge clk_core);
        set_check(kind_led, 32'h00);
        repeat (2) @(negedge clk_core);
        set_check(kind_rdata, '0);
        @(negedge clk_core);
        end_test();

        // ram through the operand bus
        for (int i = 0; i < ram_ops; i++) begin
            if ($urandom % 4 == 0) bus_idle(1); // gap, read word must hold
            if (i < 16 || $urandom % 2 == 1) begin
                bus_cycle(1'b1, $urandom % ram_words, $urandom);
            end else begin
                if ($urandom % 2 == 1) addr = written[$urandom % written.size()];
                else addr = $urandom % ram_words;
                bus_cycle(1'b0, addr, '0);
            end
        end
        bus_idle(2);
        end_test();

        // instruction port, upper address bits ignored
        insn_next = ram_model[insn_addr[ram_addr_bits-1:0]];
        for (int i = 0; i < fetch_ops; i++) begin
            if ($urandom % 2 == 1) addr = written[$urandom % written.size()];
            else addr = $urandom;
            fetch_cycle(addr);
        end
        set_check(kind_insn, insn_next);
        @(negedge clk_core);
        end_test();

        // display value and one full scan
        for (int i = 0; i < disp_vals; i++) begin
            bus_cycle(1'b1, seg7_addr, $urandom);
            bus_cycle(1'b0, seg7_addr, '0);
            bus_idle(2);
            set_check(kind_scan, {16'h0, disp_model});
            oper_strobe = 1'b0;
            repeat (16) @(negedge clk_core);
        end
        end_test();

        // control register, then unmapped space
        for (int i = 0; i < ctrl_writes; i++) begin
            bus_cycle(1'b1, ctrl_addr, $urandom);
            set_check(kind_led, {24'h0, halt_model, 1'b0});
            oper_strobe = 1'b0;
            @(negedge clk_core);
            bus_cycle(1'b0, ctrl_addr, '0);
            bus_idle(1);
        end
        for (int i = 0; i < unmapped_ops; i++) begin
            addr = unmapped_address(i);
            bus_cycle(1'b0, addr, '0);
            bus_cycle(1'b1, addr, $urandom);
            bus_cycle(1'b0, seg7_addr, '0);
            bus_cycle(1'b0, ctrl_addr, '0);
            bus_cycle(1'b0, {22'h0, addr[9:0]}, '0); // aliased ram word untouched
            bus_idle(1);
        end
        bus_idle(1);
        end_test();

        run_done = 1'b1;
        @(negedge clk_core);
        run_done = 1'b0;
        if (err_total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/tenyr_soc_pkg.sv
hdl/system_control.sv
hdl/bus_fabric.sv
hdl/block_ram.sv
hdl/seg7_display.sv
hdl/tenyr_soc.sv
sim/soc_checker.sv
sim/tb_tenyr_soc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_tenyr_soc
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hdl/*.sv sim/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
